//--- logic/coreTop.sv
`timescale 1ns/1ns
`default_nettype none

module coreTop (
  input  logic        gclk,
  input  logic        grst,
  input  logic        insnValid,
  input  logic [31:0] insnData,
  output logic        insnReady,
  output logic        wbValid,
  output logic [4:0]  wbReg,
  output logic [31:0] wbData
);
  import coreTypes::*;

  logic [4:0]         rdAddrA;
  logic [4:0]         rdAddrB;
  logic [31:0]        rdDataA;
  logic [31:0]        rdDataB;
  logic [1:0]         srcSel;
  logic [1:0]         tgtSel;
  logic [1:0]         altSel;
  logic [2:0]         aluSel;
  logic [1:0]         logFn;
  logic               sftLogic;
  logic [31:0]        immExt;
  logic               memWe;
  logic               memRe;
  logic               mulHold;
  logic               wrEn;
  logic [4:0]         wrAddr;
  logic [DMEM_AW-1:0] memAddr;
  logic [31:0]        memWrData;
  logic               memWrEn;
  logic [31:0]        memRdData;
  logic [31:0]        wbValue;

  pipeCtrl ctrl (
    .gclk, .grst, .insnValid, .insnData, .insnReady,
    .rdAddrA, .rdAddrB, .srcSel, .tgtSel, .altSel, .aluSel, .logFn, .sftLogic,
    .immExt, .memWe, .memRe, .mulHold, .wrEn, .wrAddr
  );

  regFile regs (
    .gclk, .grst, .rdAddrA, .rdAddrB, .wrEn, .wrAddr,
    .wrData (wbValue), .rdDataA, .rdDataB
  );

  execUnit exec (
    .gclk, .grst, .rdDataA, .rdDataB, .srcSel, .tgtSel, .altSel, .aluSel,
    .logFn, .sftLogic, .immExt, .memWe, .memRe, .mulHold, .memRdData,
    .memAddr, .memWrData, .memWrEn, .wbValue
  );

  dataMem dmem (.gclk, .memAddr, .memWrData, .memWrEn, .memRdData);

  // Writeback port is the register write itself
  assign wbValid = wrEn;
  assign wbReg   = wrAddr;
  assign wbData  = wbValue;

endmodule

`default_nettype wire

//--- logic/coreTypes.sv
`default_nettype none

package coreTypes;

  // Opcodes, bit 3 set marks the immediate form
  localparam logic [5:0] OP_ADD   = 6'o00;
  localparam logic [5:0] OP_RSUB  = 6'o01;
  localparam logic [5:0] OP_MUL   = 6'o20;
  localparam logic [5:0] OP_ADDI  = 6'o10;
  localparam logic [5:0] OP_RSUBI = 6'o11;
  localparam logic [5:0] OP_MULI  = 6'o30;
  localparam logic [5:0] OP_OR    = 6'o40;
  localparam logic [5:0] OP_AND   = 6'o41;
  localparam logic [5:0] OP_XOR   = 6'o42;
  localparam logic [5:0] OP_ORI   = 6'o50;
  localparam logic [5:0] OP_ANDI  = 6'o51;
  localparam logic [5:0] OP_XORI  = 6'o52;
  localparam logic [5:0] OP_SFT   = 6'o44;  // alt[0] high for logical
  localparam logic [5:0] OP_LW    = 6'o62;
  localparam logic [5:0] OP_LWI   = 6'o72;
  localparam logic [5:0] OP_SW    = 6'o66;
  localparam logic [5:0] OP_SWI   = 6'o76;

  // Operand mux selects
  localparam logic [1:0] SEL_REG = 2'o0;
  localparam logic [1:0] SEL_FWD = 2'o1;  // Value now in writeback
  localparam logic [1:0] SEL_WB  = 2'o2;  // Value retired last cycle
  localparam logic [1:0] SEL_IMM = 2'o3;

  // ALU result selects
  localparam logic [2:0] ALU_ADD  = 3'o0;
  localparam logic [2:0] ALU_LOG  = 3'o1;
  localparam logic [2:0] ALU_SFT  = 3'o2;
  localparam logic [2:0] ALU_PASS = 3'o3;
  localparam logic [2:0] ALU_MUL  = 3'o4;

  // Logic function, straight from opcode bits 1:0
  localparam logic [1:0] LOG_OR  = 2'd0;
  localparam logic [1:0] LOG_AND = 2'd1;
  localparam logic [1:0] LOG_XOR = 2'd2;

  localparam int DMEM_WORDS = 64;
  localparam int DMEM_AW    = 6;   // Word address, byte address bits 7:2

  typedef struct packed {
    logic [5:0]  opc;
    logic [4:0]  rd;
    logic [4:0]  ra;
    logic [4:0]  rb;
    logic [10:0] alt;
  } insnA;

  typedef struct packed {
    logic [5:0]  opc;
    logic [4:0]  rd;
    logic [4:0]  ra;
    logic [15:0] imm;
  } insnB;

  // Same word seen as register form or immediate form
  typedef union packed {
    insnA a;
    insnB b;
  } insnWord;

endpackage

`default_nettype wire

//--- logic/dataMem.sv
`timescale 1ns/1ns
`default_nettype none

module dataMem (
  input  logic                          gclk,
  input  logic [coreTypes::DMEM_AW-1:0] memAddr,
  input  logic [31:0]                   memWrData,
  input  logic                          memWrEn,
  output logic [31:0]                   memRdData
);
  import coreTypes::*;

  logic [31:0] mem [DMEM_WORDS];

  // Store in execute, the load one cycle later reads the updated word
  always_ff @(posedge gclk) begin
    if (memWrEn)
      mem[memAddr] <= memWrData;
  end

  // Registered read, data lines up with the writeback stage
  always_ff @(posedge gclk) begin
    memRdData <= mem[memAddr];
  end

endmodule

`default_nettype wire

//--- logic/execUnit.sv
`timescale 1ns/1ns
`default_nettype none

module execUnit (
  input  logic                          gclk,
  input  logic                          grst,
  input  logic [31:0]                   rdDataA,
  input  logic [31:0]                   rdDataB,
  input  logic [1:0]                    srcSel,
  input  logic [1:0]                    tgtSel,
  input  logic [1:0]                    altSel,
  input  logic [2:0]                    aluSel,
  input  logic [1:0]                    logFn,
  input  logic                          sftLogic,
  input  logic [31:0]                   immExt,
  input  logic                          memWe,
  input  logic                          memRe,
  input  logic                          mulHold,
  input  logic [31:0]                   memRdData,
  output logic [coreTypes::DMEM_AW-1:0] memAddr,
  output logic [31:0]                   memWrData,
  output logic                          memWrEn,
  output logic [31:0]                   wbValue
);
  import coreTypes::*;

  logic [1:0]  xSrcSel;
  logic [1:0]  xTgtSel;
  logic [1:0]  xAltSel;
  logic [2:0]  xAluSel;
  logic [1:0]  xLogFn;
  logic        xSftLogic;
  logic        xMemWe;
  logic        xMemRe;
  logic        wbLoad;     // Writeback takes the memory output
  logic [31:0] xDataA;
  logic [31:0] xDataB;
  logic [31:0] xImm;
  logic [31:0] mulA;
  logic [31:0] mulB;
  logic [31:0] result;
  logic [31:0] lastWb;
  logic [31:0] opA;
  logic [31:0] opB;
  logic [31:0] sumOut;
  logic [31:0] logOut;
  logic [31:0] aluOut;
  logic [31:0] effAddr;

  always_comb begin
    case (xSrcSel)
      SEL_FWD: opA = wbValue;
      SEL_WB:  opA = lastWb;
      SEL_IMM: opA = xImm;
      default: opA = xDataA;
    endcase
    case (xTgtSel)
      SEL_FWD: opB = wbValue;
      SEL_WB:  opB = lastWb;
      SEL_IMM: opB = xImm;
      default: opB = xDataB;
    endcase
    case (xAltSel)
      SEL_FWD: memWrData = wbValue;
      SEL_WB:  memWrData = lastWb;
      default: memWrData = xDataB;   // Port B carried rd
    endcase
  end

  assign sumOut  = xLogFn[0] ? (opB - opA) : (opB + opA);  // rsub is rb - ra
  assign effAddr = opA + opB;
  assign memAddr = effAddr[DMEM_AW+1:2];
  assign memWrEn = xMemWe;

  always_comb begin
    case (xLogFn)
      LOG_AND: logOut = opA & opB;
      LOG_XOR: logOut = opA ^ opB;
      LOG_OR:  logOut = opA | opB;
      default: logOut = opA | opB;
    endcase
    case (xAluSel)
      ALU_ADD:  aluOut = sumOut;
      ALU_LOG:  aluOut = logOut;
      ALU_SFT:  aluOut = {shiftFill(xSftLogic, opA[31]), opA[31:1]};
      ALU_MUL:  aluOut = mulA * mulB;  // Low word of the product
      ALU_PASS: aluOut = opB;
      default:  aluOut = 32'd0;
    endcase
  end

  // Fill bit for the one-bit right shift
  function automatic logic shiftFill(input logic logical, input logic sign);
    return logical ? 1'b0 : sign;
  endfunction

  always_ff @(posedge gclk) begin
    if (grst) begin
      xSrcSel   <= SEL_REG;
      xTgtSel   <= SEL_REG;
      xAltSel   <= SEL_REG;
      xAluSel   <= ALU_PASS;
      xLogFn    <= LOG_OR;
      xSftLogic <= 1'b0;
      xMemWe    <= 1'b0;
      xMemRe    <= 1'b0;
      wbLoad    <= 1'b0;
    end else begin
      if (!mulHold) begin      // Execute holds the multiply for its second cycle
        xSrcSel   <= srcSel;
        xTgtSel   <= tgtSel;
        xAltSel   <= altSel;
        xAluSel   <= aluSel;
        xLogFn    <= logFn;
        xSftLogic <= sftLogic;
        xMemWe    <= memWe;
        xMemRe    <= memRe;
      end
      wbLoad <= xMemRe & ~mulHold;
    end
  end

  always_ff @(posedge gclk) begin
    if (!mulHold) begin
      xDataA <= rdDataA;
      xDataB <= rdDataB;
      xImm   <= immExt;
      result <= aluOut;
    end else begin
      mulA <= opA;            // Forwarded values would be gone next cycle
      mulB <= opB;
    end
    lastWb <= wbValue;
  end

  assign wbValue = wbLoad ? memRdData : result;

endmodule

`default_nettype wire

//--- logic/pipeCtrl.sv
`timescale 1ns/1ns
`default_nettype none

module pipeCtrl (
  input  logic               gclk,
  input  logic               grst,
  input  logic               insnValid,
  input  coreTypes::insnWord insnData,
  output logic               insnReady,
  output logic [4:0]         rdAddrA,
  output logic [4:0]         rdAddrB,
  output logic [1:0]         srcSel,
  output logic [1:0]         tgtSel,
  output logic [1:0]         altSel,
  output logic [2:0]         aluSel,
  output logic [1:0]         logFn,
  output logic               sftLogic,
  output logic [31:0]        immExt,
  output logic               memWe,
  output logic               memRe,
  output logic               mulHold,
  output logic               wrEn,
  output logic [4:0]         wrAddr
);
  import coreTypes::*;

  insnWord     dInsn;    // Instruction sitting in decode
  logic        dValid;
  logic [5:0]  opc;
  logic [4:0]  rd;
  logic [4:0]  ra;
  logic [4:0]  rb;
  logic [15:0] imm;
  logic        known;
  logic        isMul;
  logic        isLoad;
  logic        isStore;
  logic        dWrite;
  logic        xWe;      // Execute stage destination
  logic [4:0]  xRd;
  logic        wWe;      // Writeback stage destination
  logic [4:0]  wRd;

  // Youngest producer wins, r0 never matches since its enables are dropped
  function automatic logic [1:0] fwdSel(input logic [4:0] r);
    if (xWe && (xRd == r))
      return SEL_FWD;
    else if (wWe && (wRd == r))
      return SEL_WB;
    else
      return SEL_REG;
  endfunction

  assign opc = dInsn.a.opc;
  assign rd  = dInsn.a.rd;
  assign ra  = dInsn.a.ra;
  assign rb  = dInsn.a.rb;
  assign imm = dInsn.b.imm;

  always_comb begin
    known   = 1'b1;
    isMul   = 1'b0;
    isLoad  = 1'b0;
    isStore = 1'b0;
    aluSel  = ALU_PASS;
    case (opc)
      OP_ADD, OP_RSUB, OP_ADDI, OP_RSUBI: aluSel = ALU_ADD;
      OP_OR, OP_AND, OP_XOR, OP_ORI, OP_ANDI, OP_XORI: aluSel = ALU_LOG;
      OP_SFT: aluSel = ALU_SFT;
      OP_MUL, OP_MULI: begin
        aluSel = ALU_MUL;
        isMul  = 1'b1;
      end
      OP_LW, OP_LWI: isLoad = 1'b1;
      OP_SW, OP_SWI: isStore = 1'b1;
      default: known = 1'b0;  // Treated as a no-op
    endcase
  end

  // Stores read rd on port B, so a register-form store addresses by ra alone
  assign rdAddrA = ra;
  assign rdAddrB = isStore ? rd : rb;

  assign srcSel = fwdSel(ra);
  assign tgtSel = (opc[3] || isStore) ? SEL_IMM : fwdSel(rb);
  assign altSel = isStore ? fwdSel(rd) : SEL_REG;

  assign logFn    = opc[1:0];       // Bit 0 also picks rsub over add
  assign sftLogic = dInsn.a.alt[0];
  assign immExt   = opc[3] ? {{16{imm[15]}}, imm} : 32'd0;

  assign memWe  = dValid & isStore;
  assign memRe  = dValid & isLoad;
  assign dWrite = dValid & known & ~isStore & (rd != 5'd0);

  // No issue while a multiply is in decode, leaves a bubble behind it
  assign insnReady = ~(dValid & isMul);

  always_ff @(posedge gclk) begin
    if (insnValid && insnReady)
      dInsn <= insnData;
  end

  always_ff @(posedge gclk) begin
    if (grst) begin
      dValid  <= 1'b0;
      mulHold <= 1'b0;
      xWe     <= 1'b0;
      xRd     <= 5'd0;
      wWe     <= 1'b0;
      wRd     <= 5'd0;
    end else begin
      dValid  <= insnValid & insnReady;
      mulHold <= dValid & isMul;    // First execute cycle of a multiply
      if (!mulHold) begin
        xWe <= dWrite;
        xRd <= rd;
      end
      wWe <= xWe & ~mulHold;        // Bubble into writeback during the hold
      wRd <= xRd;
    end
  end

  assign wrEn   = wWe;
  assign wrAddr = wRd;

endmodule

`default_nettype wire

//--- logic/regFile.sv
`timescale 1ns/1ns
`default_nettype none

module regFile (
  input  logic        gclk,
  input  logic        grst,
  input  logic [4:0]  rdAddrA,
  input  logic [4:0]  rdAddrB,
  input  logic        wrEn,
  input  logic [4:0]  wrAddr,
  input  logic [31:0] wrData,
  output logic [31:0] rdDataA,
  output logic [31:0] rdDataB
);

  logic [31:0] regs [32];

  always_ff @(posedge gclk) begin
    if (grst) begin
      for (int i = 0; i < 32; i++)
        regs[i] <= 32'd0;
    end else if (wrEn && (wrAddr != 5'd0)) begin
      regs[wrAddr] <= wrData;
    end
  end

  // Write-through so decode sees the value retiring this cycle
  always_comb begin
    if (rdAddrA == 5'd0)
      rdDataA = 32'd0;
    else if (wrEn && (wrAddr == rdAddrA))
      rdDataA = wrData;
    else
      rdDataA = regs[rdAddrA];

    if (rdAddrB == 5'd0)
      rdDataB = 32'd0;
    else if (wrEn && (wrAddr == rdAddrB))
      rdDataB = wrData;
    else
      rdDataB = regs[rdAddrB];
  end

endmodule

`default_nettype wire

//--- run.sh
#!/usr/bin/env bash
# Builds the core testbench with Verilator, runs it and checks the log
set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=build
LOG=sim.log

verilator --binary --timing -f tb.f --top-module coreTb -Mdir "$BUILD_DIR" -o coreSim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$BUILD_DIR/coreSim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qx "all tests passed" "$LOG"; then
  echo "PASS"
  exit 0
fi

echo "FAIL"
exit 1

//--- tb.f
+incdir+tb
logic/coreTypes.sv
logic/pipeCtrl.sv
logic/regFile.sv
logic/execUnit.sv
logic/dataMem.sv
logic/coreTop.sv
tb/coreTb.sv

//--- tb/isaModel.svh
`ifndef ISA_MODEL_SVH
`define ISA_MODEL_SVH

// Architectural state, updated in issue order
logic [31:0] archRegs [32];
logic [31:0] archMem [DMEM_WORDS];
bit          memWritten [DMEM_WORDS];  // Only stored words are ever loaded

task automatic clearModel();
  for (int i = 0; i < 32; i++)
    archRegs[i] = 32'd0;
  for (int i = 0; i < DMEM_WORDS; i++)
    memWritten[i] = 1'b0;
endtask

// One instruction, returns whether it writes a register and the value
task automatic execModel(input insnWord w, output bit writes, output logic [31:0] value);
  logic [31:0] a;
  logic [31:0] b;
  logic [31:0] imm;
  logic [31:0] addr;
  a      = archRegs[w.a.ra];
  b      = archRegs[w.a.rb];
  imm    = {{16{w.b.imm[15]}}, w.b.imm};
  addr   = 32'd0;
  writes = 1'b1;
  value  = 32'd0;
  case (w.a.opc)
    OP_ADD:   value = b + a;
    OP_RSUB:  value = b - a;
    OP_ADDI:  value = imm + a;
    OP_RSUBI: value = imm - a;
    OP_MUL:   value = a * b;
    OP_MULI:  value = a * imm;
    OP_OR:    value = a | b;
    OP_AND:   value = a & b;
    OP_XOR:   value = a ^ b;
    OP_ORI:   value = a | imm;
    OP_ANDI:  value = a & imm;
    OP_XORI:  value = a ^ imm;
    OP_SFT:   value = {(w.a.alt[0] ? 1'b0 : a[31]), a[31:1]};  // alt[0] high is logical
    OP_LW, OP_LWI: begin
      addr  = (w.a.opc == OP_LWI) ? a + imm : a + b;
      value = archMem[addr[7:2]];
    end
    OP_SW, OP_SWI: begin
      // Register form carries rd on the B port, so it addresses by ra alone
      addr = (w.a.opc == OP_SWI) ? a + imm : a;
      archMem[addr[7:2]]    = archRegs[w.a.rd];
      memWritten[addr[7:2]] = 1'b1;
      writes = 1'b0;
    end
    default: writes = 1'b0;
  endcase
  if (w.a.rd == 5'd0)
    writes = 1'b0;
  if (writes)
    archRegs[w.a.rd] = value;
endtask

`endif

//--- tb/coreTb.sv
`timescale 1ns/1ns
`default_nettype none

module coreTb;
  import coreTypes::*;

  localparam int NUM_INSNS  = 400;
  localparam int RST_CYCLES = 16;
  localparam int CLK_PERIOD = 100;
  localparam int MAX_NS     = (RST_CYCLES + NUM_INSNS * 3 + 50) * CLK_PERIOD;

  localparam logic [5:0] OPS [17] = '{OP_ADD, OP_RSUB, OP_ADDI, OP_RSUBI, OP_MUL, OP_MULI,
    OP_OR, OP_AND, OP_XOR, OP_ORI, OP_ANDI, OP_XORI, OP_SFT, OP_LW, OP_LWI, OP_SW, OP_SWI};

  logic        gclk;
  logic        grst;
  logic        insnValid;
  logic [31:0] insnData;
  logic        insnReady;
  logic        wbValid;
  logic [4:0]  wbReg;
  logic [31:0] wbData;

  integer seed;
  int     valueErrs;
  int     fwdErrs;      // Subset of valueErrs
  int     stallErrs;
  int     otherErrs;
  int     fwdCases;
  int     mulCount;
  int     loadCount;
  int     wbCount;
  int     issued;

  logic [4:0]  expReg [$];
  logic [31:0] expData [$];
  bit          expFwd [$];

  // Destinations of the last two accepted instructions
  bit          lastWe;
  logic [4:0]  lastRd;
  bit          prevWe;
  logic [4:0]  prevRd;
  bit          prevStore;
  logic [5:0]  prevStoreWord;

  `include "isaModel.svh"

  coreTop dut (
    .gclk, .grst, .insnValid, .insnData, .insnReady, .wbValid, .wbReg, .wbData
  );

  initial begin
    gclk = 1'b0;
    forever #(CLK_PERIOD / 2) gclk = ~gclk;
  end

  initial begin
    #(MAX_NS);
    $display("Watchdog expired at %0t ns, %0d of %0d instructions issued",
             $time, issued, NUM_INSNS);
    $display("tests failed");
    $finish;
  end

  function automatic logic [4:0] pickReg();
    logic [31:0] r;
    r = $random(seed);
    return {2'b00, r[2:0]};  // r0 to r7 keeps dependencies dense
  endfunction

  function automatic bit dependsOnRecent(input insnWord w);
    bit readsRb;
    bit hit;
    readsRb = !w.a.opc[3] && (w.a.opc != OP_SFT) && (w.a.opc != OP_SW);
    hit = (lastWe && lastRd == w.a.ra) || (prevWe && prevRd == w.a.ra);
    if (readsRb)
      hit = hit || (lastWe && lastRd == w.a.rb) || (prevWe && prevRd == w.a.rb);
    if (w.a.opc == OP_SW || w.a.opc == OP_SWI)
      hit = hit || (lastWe && lastRd == w.a.rd) || (prevWe && prevRd == w.a.rd);
    return hit;
  endfunction

  task automatic makeInsn(output insnWord w);
    logic [31:0] rnd;
    logic [31:0] fill;
    logic [4:0]  idx;
    logic [5:0]  opc;
    logic [5:0]  word;
    bit          isLoad;
    rnd  = $random(seed);
    fill = $random(seed);
    idx  = 5'(rnd % 17);
    opc  = OPS[idx];
    word = 6'd0;
    if (prevStore && rnd[20])
      opc = OP_LWI;               // Load right behind a store
    w = fill;                     // Random alt and imm bits
    w.a.opc = opc;
    w.a.rd  = pickReg();
    w.a.ra  = pickReg();
    if (!opc[3])
      w.a.rb = pickReg();
    if (issued < 8) begin
      w.a.opc = OP_ADDI;          // Seed r0 to r7
      w.a.rd  = 5'(issued);
      w.a.ra  = 5'd0;
    end else if (opc == OP_LW || opc == OP_LWI || opc == OP_SW || opc == OP_SWI) begin
      isLoad = (opc == OP_LW || opc == OP_LWI);
      word   = {3'b000, rnd[10:8]};
      if (isLoad && prevStore && rnd[21])
        word = prevStoreWord;
      if (isLoad && !memWritten[word])
        isLoad = 1'b0;            // Turns into a store
      w.a.ra = 5'd0;
      if (word == 6'd0 && !opc[3]) begin
        w.a.opc = isLoad ? OP_LW : OP_SW;
        w.a.rb  = 5'd0;
      end else begin
        w.a.opc = isLoad ? OP_LWI : OP_SWI;
        w.b.imm = {8'h00, word, 2'b00};
      end
    end
    prevStore = (w.a.opc == OP_SW || w.a.opc == OP_SWI);
    if (prevStore)
      prevStoreWord = word;
  endtask

  task automatic acceptInsn(input insnWord w, output bit wasMul);
    bit          writes;
    bit          fwd;
    logic [31:0] value;
    fwd = dependsOnRecent(w);
    if (fwd)
      fwdCases++;
    execModel(w, writes, value);
    if (writes) begin
      expReg.push_back(w.a.rd);
      expData.push_back(value);
      expFwd.push_back(fwd);
    end
    prevWe = lastWe;
    prevRd = lastRd;
    lastWe = writes;
    lastRd = w.a.rd;
    wasMul = (w.a.opc == OP_MUL) || (w.a.opc == OP_MULI);
    if (wasMul)
      mulCount++;
    if (w.a.opc == OP_LW || w.a.opc == OP_LWI)
      loadCount++;
  endtask

  task automatic compareWriteback();
    logic [4:0]  eReg;
    logic [31:0] eData;
    bit          eFwd;
    if (wbValid === 1'b0)
      return;
    if (wbValid !== 1'b1) begin
      otherErrs++;
      $display("wbValid is unknown at %0t", $time);
      return;
    end
    wbCount++;
    if (wbReg == 5'd0) begin
      otherErrs++;
      $display("Writeback to r0 at %0t", $time);
    end
    if (expReg.size() == 0) begin
      otherErrs++;
      $display("Writeback to r%0d at %0t with no instruction expecting one", wbReg, $time);
      return;
    end
    eReg  = expReg.pop_front();
    eData = expData.pop_front();
    eFwd  = expFwd.pop_front();
    if (wbReg !== eReg) begin
      valueErrs++;
      if (eFwd)
        fwdErrs++;
      $display("ERR %0t wbReg expected %0d got %0d", $time, eReg, wbReg);
    end
    if (wbData !== eData) begin
      valueErrs++;
      if (eFwd)
        fwdErrs++;
      $display("ERR %0t wbData expected %08h got %08h", $time, eData, wbData);
    end
  endtask

  task automatic expectIdle(input string when);
    if (wbValid !== 1'b0) begin
      otherErrs++;
      $display("wbValid not low %s at %0t", when, $time);
    end
    if (insnReady !== 1'b1) begin
      otherErrs++;
      $display("insnReady not high %s at %0t", when, $time);
    end
  endtask

  task automatic verifyReady(input bit mulJust);
    if (mulJust && insnReady !== 1'b0) begin
      stallErrs++;
      $display("insnReady stayed high in the cycle after a multiply at %0t", $time);
    end else if (!mulJust && insnReady !== 1'b1) begin
      stallErrs++;
      $display("insnReady low at %0t with no multiply just accepted", $time);
    end
  endtask

  initial begin
    insnWord     nextInsn;
    logic [31:0] rnd;
    bit          accepted;
    bit          readyPrev;
    bit          mulJust;
    int          drainCycles;
    seed      = 32'hba8a_05f3;
    grst      = 1'b1;
    insnValid = 1'b0;
    insnData  = 32'd0;
    valueErrs = 0;
    fwdErrs   = 0;
    stallErrs = 0;
    otherErrs = 0;
    fwdCases  = 0;
    mulCount  = 0;
    loadCount = 0;
    wbCount   = 0;
    issued    = 0;
    lastWe    = 1'b0;
    lastRd    = 5'd0;
    prevWe    = 1'b0;
    prevRd    = 5'd0;
    prevStore = 1'b0;
    prevStoreWord = 6'd0;
    readyPrev = 1'b0;
    clearModel();

    repeat (RST_CYCLES) begin
      @(negedge gclk);
      expectIdle("during reset");
    end
    grst = 1'b0;
    repeat (2) begin
      @(negedge gclk);
      expectIdle("after reset");
    end

    // Outputs are registered, so everything is sampled on the falling edge
    while (issued < NUM_INSNS || insnValid) begin
      @(negedge gclk);
      compareWriteback();
      accepted = insnValid && readyPrev;  // Handshake at the last rising edge
      mulJust  = 1'b0;
      if (accepted)
        acceptInsn(insnData, mulJust);
      verifyReady(mulJust);
      readyPrev = insnReady;
      rnd = $random(seed);
      if (insnValid && !accepted) begin
        insnValid = 1'b1;                 // Held, data stays put
      end else if (issued < NUM_INSNS && rnd[1:0] != 2'b00) begin
        makeInsn(nextInsn);
        insnData  = nextInsn;
        insnValid = 1'b1;
        issued++;
      end else begin
        insnValid = 1'b0;
      end
    end

    drainCycles = 0;
    while (expReg.size() != 0 && drainCycles < 20) begin
      @(negedge gclk);
      compareWriteback();
      verifyReady(1'b0);
      drainCycles++;
    end
    repeat (4) begin
      @(negedge gclk);
      compareWriteback();
    end
    if (expReg.size() != 0) begin
      otherErrs++;
      $display("%0d expected writebacks never arrived", expReg.size());
    end

    $write("Errors: %0d value (%0d on forwarded operands), %0d stall, %0d other; ",
           valueErrs, fwdErrs, stallErrs, otherErrs);
    $display("%0d writebacks, %0d forwarded, %0d multiplies, %0d loads",
             wbCount, fwdCases, mulCount, loadCount);
    if (valueErrs + stallErrs + otherErrs == 0)
      $display("all tests passed");
    else
      $display("tests failed");
    $finish;
  end

endmodule

`default_nettype wire
